//--- miss_handler_top.f
common/cache_pkg.sv
common/mem_op_pkg.sv
mshr/mshr_queue.sv
mshr/mshr.sv
rtl/l2_request_issuer.sv
rtl/miss_handler_top.sv
verification/mshr_props.sv
verification/miss_handler_tb.sv

//--- verification/miss_handler_tb.sv
`timescale 1ns/1ps
`default_nettype none

module miss_handler_tb
    import cache_pkg::*;
    import mem_op_pkg::*;
();

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       alloc = 1'b0;
    addr_t      alloc_addr = '0;
    mem_op_t    alloc_op = OP_NOP;
    logic       l2_req_ready = 1'b0;
    logic       l2_resp_valid = 1'b0;
    line_addr_t l2_resp_addr = '0;
    logic       l2_resp_store = 1'b0;

    logic       mshr_hit;
    logic       mshr_fin;
    logic       mshr_full;
    mshr_idx_t  mshr_hit_ptr;
    mshr_idx_t  mshr_fin_ptr;
    mshr_idx_t  mshr_wr_ptr;
    logic       l2_req_valid;
    line_addr_t l2_req_addr;
    logic       l2_req_store;

    // slot model
    logic       m_valid [MSHR_DEPTH];
    logic       m_done  [MSHR_DEPTH];
    line_addr_t m_line  [MSHR_DEPTH];
    logic       m_store [MSHR_DEPTH];
    mshr_idx_t  m_head;
    mshr_idx_t  m_tail;
    int         m_count;

    line_addr_t req_line_q [$];   // queued, not yet sent
    logic       req_store_q [$];
    line_addr_t sent_line_q [$];  // sent, awaiting refill
    logic       sent_store_q [$];
    int         exp_req_cnt;
    line_addr_t exp_req_line;
    logic       exp_req_store;
    int         hit_slot;
    int         fin_slot;

    logic        alloc_en = 1'b0;
    int          ready_mode = 0;  // 0 random, 1 stalled, 2 always ready
    int          resp_mode = 0;   // 0 off, 1 random order, 2 youngest first
    logic [31:0] lcg_state = 32'h52705375;

    miss_handler_top i_miss_handler_top (.*);

    bind miss_handler_top mshr_props i_mshr_props (
        .*,
        .hit_vec (i_mshr.hit_vec),
        .fin_vec (i_mshr.fin_vec)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    // open slot holding this line and store flag, or -1
    function automatic int find_open(input line_addr_t line, input logic store);
        int slot;
        slot = -1;
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            if (m_valid[i] && !m_done[i] && m_line[i] == line && m_store[i] == store) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    function automatic logic model_idle();
        return m_count == 0 && req_line_q.size() == 0 && sent_line_q.size() == 0;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t ns", what, $time);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic wait_for_idle(input int limit);
        int n;
        n = 0;
        while (!model_idle() && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!model_idle()) begin
            report_failure("timeout waiting for all misses to retire");
        end
    endtask

    task automatic wait_for_full_issued(input int limit);
        int n;
        n = 0;
        while (!(m_count == MSHR_DEPTH && req_line_q.size() == 0) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!(m_count == MSHR_DEPTH && req_line_q.size() == 0)) begin
            report_failure("timeout waiting for all slots to fill and issue");
        end
    endtask

    always_comb begin
        hit_slot = find_open(alloc_addr[ADDR_BITS-1:LINE_OFFSET_BITS], alloc_op == OP_STORE);
        fin_slot = l2_resp_valid ? find_open(l2_resp_addr, l2_resp_store) : -1;
    end

    // model update from the inputs of the closing cycle, then next inputs
    always @(posedge clk) begin : model_and_stimulus
        int          slot;
        int          pick;
        logic        retire;
        logic        xfer;
        logic [31:0] r;
        line_addr_t  key_line;
        mem_op_t     key_op;

        if (rst) begin
            for (int i = 0; i < MSHR_DEPTH; i++) begin
                m_valid[i] = 1'b0;
                m_done[i]  = 1'b0;
            end
            m_head  = '0;
            m_tail  = '0;
            m_count = 0;
            req_line_q.delete();
            req_store_q.delete();
            sent_line_q.delete();
            sent_store_q.delete();
        end else begin
            slot   = l2_resp_valid ? find_open(l2_resp_addr, l2_resp_store) : -1;
            retire = m_valid[m_head] && m_done[m_head];
            xfer   = req_line_q.size() != 0 && l2_req_ready;
            if (retire) begin
                m_valid[m_head] = 1'b0;
                m_done[m_head]  = 1'b0;
                m_head          = m_head + 1'b1;
                m_count--;
            end
            if (slot >= 0) begin
                m_done[slot] = 1'b1;
            end
            if (xfer) begin
                sent_line_q.push_back(req_line_q.pop_front());
                sent_store_q.push_back(req_store_q.pop_front());
            end
            if (alloc) begin
                m_valid[m_tail] = 1'b1;
                m_done[m_tail]  = 1'b0;
                m_line[m_tail]  = alloc_addr[ADDR_BITS-1:LINE_OFFSET_BITS];
                m_store[m_tail] = alloc_op == OP_STORE;
                req_line_q.push_back(m_line[m_tail]);
                req_store_q.push_back(m_store[m_tail]);
                m_tail = m_tail + 1'b1; // wraps at 8
                m_count++;
            end

            r = lcg_rand();
            key_line = line_addr_t'(32'h00c0ff00 + (r % 6)); // small pool, frequent hits
            if (r[27:24] == 4'd0) begin
                key_line = line_addr_t'(lcg_rand());
            end
            key_op = r[4] ? OP_STORE : mem_op_t'(r[7:5]);
            alloc_addr <= {key_line, r[11:8]};
            alloc_op   <= key_op;
            alloc      <= alloc_en && m_count < MSHR_DEPTH && r[13:12] != 2'd0
                          && find_open(key_line, key_op == OP_STORE) < 0;

            case (ready_mode)
                0:       l2_req_ready <= r[15:14] != 2'd0;
                1:       l2_req_ready <= 1'b0;
                default: l2_req_ready <= 1'b1;
            endcase

            l2_resp_valid <= 1'b0;
            if (resp_mode != 0 && sent_line_q.size() != 0
                && (resp_mode == 2 || r[17:16] == 2'd0)) begin
                pick = (resp_mode == 2) ? sent_line_q.size() - 1
                                        : int'(r[31:18]) % sent_line_q.size();
                l2_resp_valid <= 1'b1;
                l2_resp_addr  <= sent_line_q[pick];
                l2_resp_store <= sent_store_q[pick];
                sent_line_q.delete(pick);
                sent_store_q.delete(pick);
            end
        end
        exp_req_cnt = req_line_q.size();
        if (exp_req_cnt != 0) begin
            exp_req_line  = req_line_q[0];
            exp_req_store = req_store_q[0];
        end
    end

    assert property (@(posedge clk) disable iff (rst) mshr_wr_ptr == m_tail)
        else report_mismatch("mshr_wr_ptr", $sampled(mshr_wr_ptr), $sampled(m_tail));
    assert property (@(posedge clk) disable iff (rst) mshr_full == (m_count == MSHR_DEPTH))
        else report_mismatch("mshr_full", $sampled(mshr_full), $sampled(m_count == MSHR_DEPTH));
    assert property (@(posedge clk) disable iff (rst) mshr_hit == (hit_slot >= 0))
        else report_mismatch("mshr_hit", $sampled(mshr_hit), $sampled(hit_slot >= 0));
    assert property (@(posedge clk) disable iff (rst) hit_slot >= 0 |-> mshr_hit_ptr == hit_slot)
        else report_mismatch("mshr_hit_ptr", $sampled(mshr_hit_ptr), $sampled(hit_slot));
    assert property (@(posedge clk) disable iff (rst) mshr_fin == (fin_slot >= 0))
        else report_mismatch("mshr_fin", $sampled(mshr_fin), $sampled(fin_slot >= 0));
    assert property (@(posedge clk) disable iff (rst) fin_slot >= 0 |-> mshr_fin_ptr == fin_slot)
        else report_mismatch("mshr_fin_ptr", $sampled(mshr_fin_ptr), $sampled(fin_slot));
    assert property (@(posedge clk) disable iff (rst) l2_req_valid == (exp_req_cnt != 0))
        else report_mismatch("l2_req_valid", $sampled(l2_req_valid), $sampled(exp_req_cnt != 0));
    assert property (@(posedge clk) disable iff (rst)
        l2_req_valid && l2_req_ready |-> l2_req_addr == exp_req_line)
        else report_mismatch("l2_req_addr", $sampled(l2_req_addr), $sampled(exp_req_line));
    assert property (@(posedge clk) disable iff (rst)
        l2_req_valid && l2_req_ready |-> l2_req_store == exp_req_store)
        else report_mismatch("l2_req_store", $sampled(l2_req_store), $sampled(exp_req_store));
    assert property (@(posedge clk) i_miss_handler_top.i_mshr_props.failures == 0)
        else report_failure("a protocol assertion in mshr_props failed");

    initial begin
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // random misses, ready gaps, refills in any order
        alloc_en   = 1'b1;
        ready_mode = 0;
        resp_mode  = 1;
        repeat (3000) @(negedge clk);
        alloc_en   = 1'b0;
        ready_mode = 2;
        wait_for_idle(500);
        // all slots busy, then refill youngest first so the head finishes last
        alloc_en  = 1'b1;
        resp_mode = 0;
        wait_for_full_issued(200);
        alloc_en  = 1'b0;
        resp_mode = 2;
        wait_for_idle(200);
        // L2 stalled while misses keep coming
        ready_mode = 1;
        alloc_en   = 1'b1;
        repeat (40) @(negedge clk);
        alloc_en   = 1'b0;
        ready_mode = 0;
        resp_mode  = 1;
        wait_for_idle(500);
        repeat (5) @(negedge clk);
        if (i_miss_handler_top.i_mshr_props.failures != 0) begin
            report_failure("a protocol assertion in mshr_props failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/mshr_props.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_props
    import cache_pkg::*;
(
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  alloc,
    input wire logic                  mshr_full,
    input wire logic                  mshr_hit,
    input wire logic                  mshr_fin,
    input wire mshr_idx_t             mshr_wr_ptr,
    input wire logic                  l2_req_valid,
    input wire line_addr_t            l2_req_addr,
    input wire logic                  l2_req_store,
    input wire logic                  l2_req_ready,
    input wire logic [MSHR_DEPTH-1:0] hit_vec,
    input wire logic [MSHR_DEPTH-1:0] fin_vec
);

    int unsigned failures = 0;

    // cache side rules
    assert property (@(posedge clk) disable iff (rst) alloc |-> !mshr_full)
        else begin
            $error("alloc while mshr_full");
            failures++;
        end
    assert property (@(posedge clk) disable iff (rst) alloc |-> !mshr_hit)
        else begin
            $error("alloc while mshr_hit");
            failures++;
        end

    // request held under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        l2_req_valid && !l2_req_ready
        |=> l2_req_valid && $stable(l2_req_addr) && $stable(l2_req_store))
        else begin
            $error("l2 request changed before ready");
            failures++;
        end

    assert property (@(posedge clk) disable iff (rst) mshr_hit |-> $onehot(hit_vec))
        else begin
            $error("hit vector not one-hot");
            failures++;
        end
    assert property (@(posedge clk) disable iff (rst) mshr_fin |-> $onehot(fin_vec))
        else begin
            $error("finish vector not one-hot");
            failures++;
        end

    assert property (@(posedge clk)
        rst |=> !mshr_full && !mshr_hit && !mshr_fin && !l2_req_valid && mshr_wr_ptr == '0)
        else begin
            $error("control outputs not cleared by reset");
            failures++;
        end

endmodule

`default_nettype wire

//--- rtl/miss_handler_top.sv
`timescale 1ns/1ps
`default_nettype none

module miss_handler_top
    import cache_pkg::*;
    import mem_op_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    input  wire logic       alloc,
    input  wire addr_t      alloc_addr,
    input  wire mem_op_t    alloc_op,

    output logic            mshr_hit,
    output mshr_idx_t       mshr_hit_ptr,
    output mshr_idx_t       mshr_wr_ptr,
    output logic            mshr_full,
    output logic            mshr_fin,
    output mshr_idx_t       mshr_fin_ptr,

    output logic            l2_req_valid,
    output line_addr_t      l2_req_addr,
    output logic            l2_req_store,
    input  wire logic       l2_req_ready,

    input  wire logic       l2_resp_valid,
    input  wire line_addr_t l2_resp_addr,
    input  wire logic       l2_resp_store
);

    mshr i_mshr (
        .clk           (clk),
        .rst           (rst),
        .alloc         (alloc),
        .alloc_addr    (alloc_addr),
        .alloc_op      (alloc_op),
        .l2_resp_valid (l2_resp_valid),
        .l2_resp_addr  (l2_resp_addr),
        .l2_resp_store (l2_resp_store),
        .mshr_hit      (mshr_hit),
        .mshr_fin      (mshr_fin),
        .mshr_hit_ptr  (mshr_hit_ptr),
        .mshr_fin_ptr  (mshr_fin_ptr),
        .mshr_wr_ptr   (mshr_wr_ptr),
        .mshr_full     (mshr_full)
    );

    // same alloc stream, kept in order toward L2
    l2_request_issuer i_l2_request_issuer (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .alloc_addr   (alloc_addr),
        .alloc_op     (alloc_op),
        .l2_req_valid (l2_req_valid),
        .l2_req_addr  (l2_req_addr),
        .l2_req_store (l2_req_store),
        .l2_req_ready (l2_req_ready)
    );

endmodule

`default_nettype wire

//--- rtl/l2_request_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module l2_request_issuer
    import cache_pkg::*;
    import mem_op_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,

    input  wire logic    alloc,
    input  wire addr_t   alloc_addr,
    input  wire mem_op_t alloc_op,

    output logic         l2_req_valid,
    output line_addr_t   l2_req_addr,
    output logic         l2_req_store,
    input  wire logic    l2_req_ready
);

    line_addr_t            line_mem [MSHR_DEPTH];
    logic [MSHR_DEPTH-1:0] store_mem;

    mshr_idx_t wr_ptr_q;
    mshr_idx_t rd_ptr_q;
    mshr_cnt_t count_q;

    logic xfer;

    assign xfer = l2_req_valid && l2_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (alloc) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (xfer) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({alloc, xfer})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // slot at rd_ptr is not rewritten before it leaves
    always_ff @(posedge clk) begin
        if (alloc) begin
            line_mem[wr_ptr_q]  <= alloc_addr[ADDR_BITS-1:LINE_OFFSET_BITS];
            store_mem[wr_ptr_q] <= (alloc_op == OP_STORE);
        end
    end

    assign l2_req_valid = (count_q != '0);
    assign l2_req_addr  = line_mem[rd_ptr_q];
    assign l2_req_store = store_mem[rd_ptr_q];

endmodule

`default_nettype wire

//--- mshr/mshr.sv
`timescale 1ns/1ps
`default_nettype none

module mshr
    import cache_pkg::*;
    import mem_op_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    // miss from the cache
    input  wire logic       alloc,
    input  wire addr_t      alloc_addr,
    input  wire mem_op_t    alloc_op,

    // refill notice from L2
    input  wire logic       l2_resp_valid,
    input  wire line_addr_t l2_resp_addr,
    input  wire logic       l2_resp_store,

    output logic            mshr_hit,
    output logic            mshr_fin,
    output mshr_idx_t       mshr_hit_ptr,
    output mshr_idx_t       mshr_fin_ptr,
    output mshr_idx_t       mshr_wr_ptr,
    output logic            mshr_full
);

    line_addr_t alloc_line;
    logic       alloc_store;

    logic [MSHR_DEPTH-1:0] hit_vec;
    logic [MSHR_DEPTH-1:0] fin_vec;
    mshr_idx_t             tail;
    logic                  full;

    // zero unless exactly one bit is set
    function automatic mshr_idx_t onehot_to_idx(input logic [MSHR_DEPTH-1:0] vec);
        mshr_idx_t idx;
        idx = '0;
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            if (vec == (MSHR_DEPTH'(1) << i)) begin
                idx = mshr_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign alloc_line  = alloc_addr[ADDR_BITS-1:LINE_OFFSET_BITS];
    assign alloc_store = (alloc_op == OP_STORE); // everything else is a load

    mshr_queue i_mshr_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (alloc),
        .push_line  (alloc_line),
        .push_store (alloc_store),
        .cmp_line   (alloc_line),
        .cmp_store  (alloc_store),
        .done_line  (l2_resp_addr),
        .done_store (l2_resp_store),
        .done_en    (l2_resp_valid),
        .match_vec  (hit_vec),
        .done_vec   (fin_vec),
        .tail       (tail),
        .full       (full)
    );

    // hit looks at the current alloc key, whether or not alloc is high
    assign mshr_hit     = |hit_vec;
    assign mshr_hit_ptr = onehot_to_idx(hit_vec);

    assign mshr_fin     = |fin_vec; // already qualified by l2_resp_valid
    assign mshr_fin_ptr = onehot_to_idx(fin_vec);

    assign mshr_wr_ptr  = tail;
    assign mshr_full    = full;

endmodule

`default_nettype wire

//--- mshr/mshr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_queue
    import cache_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  push,
    input  wire line_addr_t            push_line,
    input  wire logic                  push_store,

    input  wire line_addr_t            cmp_line,
    input  wire logic                  cmp_store,

    input  wire line_addr_t            done_line,
    input  wire logic                  done_store,
    input  wire logic                  done_en,

    output logic [MSHR_DEPTH-1:0]      match_vec,
    output logic [MSHR_DEPTH-1:0]      done_vec,

    output mshr_idx_t                  tail,
    output logic                       full
);

    logic [MSHR_DEPTH-1:0] valid_q;
    logic [MSHR_DEPTH-1:0] done_q;
    line_addr_t            line_q [MSHR_DEPTH];
    logic [MSHR_DEPTH-1:0] store_q;

    mshr_idx_t head_q;
    mshr_idx_t tail_q;
    mshr_cnt_t count_q;
    logic      full_q;

    logic retire;

    // parallel compare, done entries drop out of both keys
    always_comb begin
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            match_vec[i] = valid_q[i] && !done_q[i]
                           && (line_q[i] == cmp_line) && (store_q[i] == cmp_store);
            done_vec[i]  = done_en && valid_q[i] && !done_q[i]
                           && (line_q[i] == done_line) && (store_q[i] == done_store);
        end
    end

    assign retire = valid_q[head_q] && done_q[head_q];

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            full_q  <= 1'b0;
        end else begin
            done_q <= done_q | done_vec;

            if (retire) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
                head_q          <= head_q + 1'b1; // wraps at depth
            end

            if (push) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end

            case ({push, retire})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                    full_q  <= (count_q == mshr_cnt_t'(MSHR_DEPTH - 1));
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                    full_q  <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // payload, written with the valid bit
    always_ff @(posedge clk) begin
        if (push) begin
            line_q[tail_q]  <= push_line;
            store_q[tail_q] <= push_store;
        end
    end

    assign tail = tail_q;
    assign full = full_q;

endmodule

`default_nettype wire

//--- common/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

    // cache operation codes
    // only OP_STORE is told apart by the miss logic, the rest count as loads
    typedef enum logic [2:0] {
        OP_NOP      = 3'd0,
        OP_FETCH    = 3'd1,
        OP_LOAD     = 3'd2,
        OP_STORE    = 3'd3,
        OP_PREFETCH = 3'd4,
        OP_FLUSH    = 3'd5,
        OP_INVAL    = 3'd6,
        OP_ATOMIC   = 3'd7
    } mem_op_t;

endpackage

`default_nettype wire

//--- common/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int ADDR_BITS        = 32;
    localparam int LINE_OFFSET_BITS = 4;
    localparam int LINE_ADDR_BITS   = ADDR_BITS - LINE_OFFSET_BITS;

    // outstanding misses tracked at once
    localparam int MSHR_DEPTH    = 8;
    localparam int MSHR_IDX_BITS = $clog2(MSHR_DEPTH);
    localparam int MSHR_CNT_BITS = $clog2(MSHR_DEPTH + 1);

    // byte address as seen by the cache
    typedef logic [ADDR_BITS-1:0] addr_t;

    // byte address without the offset bits
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    typedef logic [MSHR_IDX_BITS-1:0] mshr_idx_t;

    // occupancy, 0 up to MSHR_DEPTH
    typedef logic [MSHR_CNT_BITS-1:0] mshr_cnt_t;

endpackage

`default_nettype wire
